// ==== vlog.f ====
+incdir+hw
hw/glb_pkg.sv
hw/glb_csb.sv
hw/glb_reg.sv
hw/glb_intr.sv
hw/glb_top.sv
tests/tb_glb.sv

// ==== run.sh ====
#!/bin/sh
# Build the global control unit testbench with Verilator and run it.
# Exit status is 0 only when the run prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_glb -f vlog.f
if [ $? -ne 0 ]; then
  echo "run.sh: verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_glb)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "run.sh: simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TEST RESULT: PASS"; then
  exit 0
else
  echo "run.sh: pass line not found"
  exit 1
fi

// ==== tests/tb_glb.sv ====
////////////////////////////////////////
// testbench of glb_top: random csb traffic and done pulses
// checked every cycle against a register and interrupt model
////////////////////////////////////////

`timescale 1ns/1ns
`include "glb_defines.svh"

module tb_glb;

  import glb_pkg::*;

  localparam int SEED      = 44296;
  localparam int RAND_CYC  = 2000;  // mixed traffic
  localparam int BURST_CYC = 400;   // request on every cycle
  localparam int DRAIN_CYC = 6;
  localparam int MAX_CYC   = 2 * (5 + RAND_CYC + BURST_CYC + DRAIN_CYC + 1) + 100;

  typedef struct packed {
    int        due;   // cycle the response must show up in
    csb_resp_t resp;
  } exp_resp_t;

  logic      nvdla_core_clk;
  logic      nvdla_core_rstn;
  logic      req_valid;
  csb_req_t  req_pd;
  logic      resp_valid;
  csb_resp_t resp_pd;
  done_vec_t done_pulse;
  logic      core_intr;
  done_vec_t done_mask;

  // model values of the current cycle
  done_vec_t m_mask;
  done_vec_t m_status;
  logic      m_intr;
  logic      m_req_vld;
  csb_req_t  m_req;
  exp_resp_t exp_q[$];

  int cycle_cnt    = 0;
  int mismatch_cnt = 0;
  int proto_cnt    = 0;
  int resp_cnt     = 0;
  int collide_cnt  = 0;  // set and clear on one bit

  glb_top i_dut (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .req_valid       (req_valid),
    .req_pd          (req_pd),
    .resp_valid      (resp_valid),
    .resp_pd         (resp_pd),
    .done_pulse      (done_pulse),
    .core_intr       (core_intr),
    .done_mask       (done_mask)
  );

  initial begin
    nvdla_core_clk = 1'b0;
    forever #20 nvdla_core_clk = ~nvdla_core_clk;
  end

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////
  task automatic check_resp(input csb_resp_t got, input csb_resp_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH resp_pd cycle %0d: got %h expected %h", cycle_cnt, got, exp);
    end
  endtask

  task automatic check_status(input done_vec_t got, input done_vec_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH done_status cycle %0d: got %h expected %h", cycle_cnt, got, exp);
    end
  endtask

  task automatic check_mask(input done_vec_t got, input done_vec_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH done_mask cycle %0d: got %h expected %h", cycle_cnt, got, exp);
    end
  endtask

  task automatic check_intr(input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH core_intr cycle %0d: got %h expected %h", cycle_cnt, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////
  function automatic csb_req_t rand_req();
    csb_req_t    r;
    int unsigned pick;
    r.level   = 2'($urandom);
    r.wrbe    = 4'($urandom);
    r.srcpriv = 1'($urandom);
    r.nposted = 1'($urandom);
    r.write   = 1'($urandom);
    r.wdat    = $urandom;
    r.addr    = csb_addr_t'($urandom);  // upper bits ignored by the unit
    pick      = $urandom % 10;
    if (pick < 8) begin
      r.addr[9:0] = 10'(pick % 4);  // one of the four mapped words
    end
    return r;
  endfunction

  function automatic done_vec_t rand_pulse();
    if (($urandom % 100) < 30) begin
      return done_vec_t'($urandom & $urandom & $urandom);  // sparse pulses
    end
    return '0;
  endfunction

  task automatic drive_cycle(input int valid_pct);
    @(posedge nvdla_core_clk);
    req_valid  <= (($urandom % 100) < valid_pct);
    req_pd     <= rand_req();
    done_pulse <= rand_pulse();
  endtask

  ////////////////////////////////////////
  // model and per-cycle checks
  ////////////////////////////////////////
  task automatic check_outputs();
    exp_resp_t e;
    check_mask(done_mask, m_mask);
    check_status(i_dut.done_status, m_status);
    check_intr(core_intr, m_intr);
    if (resp_valid) begin
      if (exp_q.size() == 0) begin
        proto_cnt++;
        $display("cycle %0d: a response came with none expected", cycle_cnt);
      end else begin
        e = exp_q.pop_front();
        if (e.due != cycle_cnt) begin
          proto_cnt++;
          $display("cycle %0d: response due in cycle %0d came early", cycle_cnt, e.due);
        end
        check_resp(resp_pd, e.resp);
        resp_cnt++;
      end
    end else if (exp_q.size() != 0 && exp_q[0].due <= cycle_cnt) begin
      proto_cnt++;
      $display("cycle %0d: an expected response did not come", cycle_cnt);
      e = exp_q.pop_front();
    end
  endtask

  task automatic step_model();
    reg_ofs_t  ofs;
    done_vec_t wbits;
    done_vec_t set_v;
    done_vec_t clr_v;
    done_vec_t mask_nxt;
    exp_resp_t e;
    ofs      = {m_req.addr[9:0], 2'b00};
    wbits    = m_req.wdat[`GLB_NUM_DONE-1:0];
    set_v    = done_pulse;
    clr_v    = '0;
    mask_nxt = m_mask;
    e.due    = cycle_cnt + 1;
    e.resp   = '0;
    e.resp.error = !(ofs == `GLB_OFS_VERSION || ofs == `GLB_OFS_MASK ||
                     ofs == `GLB_OFS_SET || ofs == `GLB_OFS_STATUS);
    if (m_req_vld && !m_req.write) begin
      case (ofs)
        `GLB_OFS_VERSION: e.resp.rdata = `GLB_HW_VERSION;
        `GLB_OFS_MASK:    e.resp.rdata = 32'(m_mask);
        `GLB_OFS_STATUS:  e.resp.rdata = 32'(m_status);
        default:          e.resp.rdata = '0;  // set reg and holes
      endcase
      exp_q.push_back(e);
    end else if (m_req_vld) begin
      case (ofs)
        `GLB_OFS_MASK:   mask_nxt = wbits;
        `GLB_OFS_SET:    set_v = set_v | wbits;
        `GLB_OFS_STATUS: clr_v = wbits;
        default: ;                           // version and holes ignore writes
      endcase
      if (m_req.nposted) begin
        e.resp.is_write_resp = 1'b1;
        exp_q.push_back(e);
      end
    end
    if ((set_v & clr_v) != '0) begin
      collide_cnt++;
    end
    m_intr    = |(m_status & ~m_mask);  // from this cycle's values
    m_status  = (m_status & ~clr_v) | set_v;
    m_mask    = mask_nxt;
    m_req_vld = req_valid;
    if (req_valid) begin
      m_req = req_pd;
    end
  endtask

  always @(negedge nvdla_core_clk) begin
    if (nvdla_core_rstn) begin
      check_outputs();
      step_model();
    end
  end

  ////////////////////////////////////////
  // end of run
  ////////////////////////////////////////
  task automatic finish_run(input bit timed_out);
    $display("errors: %0d mismatches, %0d other, %0d responses checked",
             mismatch_cnt, proto_cnt, resp_cnt);
    if (!timed_out && mismatch_cnt == 0 && proto_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  always @(posedge nvdla_core_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYC) begin
      $display("timeout: run did not end within %0d cycles", MAX_CYC);
      finish_run(1'b1);
    end
  end

  initial begin
    void'($urandom(SEED));
    nvdla_core_rstn <= 1'b0;
    req_valid       <= 1'b0;
    req_pd          <= '0;
    done_pulse      <= '0;
    m_mask    = '0;
    m_status  = '0;
    m_intr    = 1'b0;
    m_req_vld = 1'b0;
    m_req     = '0;
    repeat (5) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
    repeat (RAND_CYC) drive_cycle(50);
    repeat (BURST_CYC) drive_cycle(100);
    repeat (DRAIN_CYC) drive_cycle(0);  // let responses drain
    @(posedge nvdla_core_clk);
    if (exp_q.size() != 0) begin
      proto_cnt++;
      $display("%0d expected responses never came", exp_q.size());
    end
    if (resp_cnt == 0) begin
      proto_cnt++;
      $display("no response was seen in the whole run");
    end
    if (collide_cnt == 0) begin
      proto_cnt++;
      $display("no set and clear on the same bit was exercised");
    end
    finish_run(1'b0);
  end

endmodule

// ==== hw/glb_top.sv ====
////////////////////////////////////////
// global control unit top: csb port, engine done pulses,
// done mask toward the engines and the core interrupt
////////////////////////////////////////

`timescale 1ns/1ns

module glb_top (
  input  logic                nvdla_core_clk,
  input  logic                nvdla_core_rstn,
  input  logic                req_valid,
  input  glb_pkg::csb_req_t   req_pd,
  output logic                resp_valid,
  output glb_pkg::csb_resp_t  resp_pd,
  input  glb_pkg::done_vec_t  done_pulse,
  output logic                core_intr,
  output glb_pkg::done_vec_t  done_mask
);

  import glb_pkg::*;

  logic      reg_wr_en;
  logic      reg_rd_en;
  reg_ofs_t  reg_offset;
  csb_data_t reg_wr_data;
  csb_data_t reg_rd_data;
  logic      reg_err;

  logic      set_en;
  done_vec_t set_bits;
  logic      clr_en;
  done_vec_t clr_bits;
  done_vec_t done_status;

  ////////////////////////////////////////
  // instances
  ////////////////////////////////////////
  glb_csb i_csb (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .req_valid       (req_valid),
    .req_pd          (req_pd),
    .reg_rd_data     (reg_rd_data),
    .reg_err         (reg_err),
    .resp_valid      (resp_valid),
    .resp_pd         (resp_pd),
    .reg_wr_en       (reg_wr_en),
    .reg_rd_en       (reg_rd_en),
    .reg_offset      (reg_offset),
    .reg_wr_data     (reg_wr_data)
  );

  glb_reg i_reg (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .reg_wr_en       (reg_wr_en),
    .reg_rd_en       (reg_rd_en),
    .reg_offset      (reg_offset),
    .reg_wr_data     (reg_wr_data),
    .done_status     (done_status),
    .reg_rd_data     (reg_rd_data),
    .reg_err         (reg_err),
    .done_mask       (done_mask),      // also goes out to the engines
    .set_en          (set_en),
    .set_bits        (set_bits),
    .clr_en          (clr_en),
    .clr_bits        (clr_bits)
  );

  glb_intr i_intr (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .done_pulse      (done_pulse),
    .set_en          (set_en),
    .set_bits        (set_bits),
    .clr_en          (clr_en),
    .clr_bits        (clr_bits),
    .done_mask       (done_mask),
    .done_status     (done_status),
    .core_intr       (core_intr)
  );

endmodule

// ==== hw/glb_intr.sv ====
////////////////////////////////////////
// done status with set over clear priority, and the
// registered core interrupt from unmasked status bits
////////////////////////////////////////

`timescale 1ns/1ns

module glb_intr (
  input  logic                nvdla_core_clk,
  input  logic                nvdla_core_rstn,
  input  glb_pkg::done_vec_t  done_pulse,
  input  logic                set_en,
  input  glb_pkg::done_vec_t  set_bits,
  input  logic                clr_en,
  input  glb_pkg::done_vec_t  clr_bits,
  input  glb_pkg::done_vec_t  done_mask,
  output glb_pkg::done_vec_t  done_status,
  output logic                core_intr
);

  import glb_pkg::*;

  done_vec_t set_vec;
  done_vec_t clr_vec;
  done_vec_t status_nxt;

  assign set_vec = done_pulse | (set_en ? set_bits : '0);  // engines or sw set
  assign clr_vec = clr_en ? clr_bits : '0;

  // a set in the same cycle beats the clear
  assign status_nxt = (done_status & ~clr_vec) | set_vec;

  ////////////////////////////////////////
  // status and interrupt flops
  ////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      done_status <= '0;
      core_intr   <= 1'b0;
    end else begin
      done_status <= status_nxt;
      core_intr   <= |(done_status & ~done_mask);  // one cycle after status
    end
  end

  // interrupt line must stay clean once out of reset
  property p_intr_known;
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
      !$isunknown(core_intr);
  endproperty
  a_intr_known: assert property (p_intr_known)
    else $error("glb_intr: core_intr is unknown");

endmodule

// ==== hw/glb_reg.sv ====
////////////////////////////////////////
// glb register file: offset decode, mask register, set and
// clear strobes toward the interrupt block, read mux
////////////////////////////////////////

`timescale 1ns/1ns
`include "glb_defines.svh"

module glb_reg (
  input  logic                nvdla_core_clk,
  input  logic                nvdla_core_rstn,
  input  logic                reg_wr_en,
  input  logic                reg_rd_en,
  input  glb_pkg::reg_ofs_t   reg_offset,
  input  glb_pkg::csb_data_t  reg_wr_data,
  input  glb_pkg::done_vec_t  done_status,
  output glb_pkg::csb_data_t  reg_rd_data,
  output logic                reg_err,
  output glb_pkg::done_vec_t  done_mask,
  output logic                set_en,
  output glb_pkg::done_vec_t  set_bits,
  output logic                clr_en,
  output glb_pkg::done_vec_t  clr_bits
);

  import glb_pkg::*;

  logic      sel_version;
  logic      sel_mask;
  logic      sel_set;
  logic      sel_status;
  done_vec_t wr_bits;

  ////////////////////////////////////////
  // offset decode
  ////////////////////////////////////////
  always_comb begin
    sel_version = 1'b0;
    sel_mask    = 1'b0;
    sel_set     = 1'b0;
    sel_status  = 1'b0;
    case (reg_offset)
      GLB_REG_VERSION: sel_version = 1'b1;
      GLB_REG_MASK:    sel_mask    = 1'b1;
      GLB_REG_SET:     sel_set     = 1'b1;
      GLB_REG_STATUS:  sel_status  = 1'b1;
      default: ;                          // unmapped
    endcase
  end

  // flags the offset only; the csb side decides if it answers
  assign reg_err = ~(sel_version | sel_mask | sel_set | sel_status);

  // only the low done bits are meaningful in a write
  assign wr_bits = reg_wr_data[`GLB_NUM_DONE-1:0];

  ////////////////////////////////////////
  // mask register
  ////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      done_mask <= '0;
    end else if (reg_wr_en && sel_mask) begin
      done_mask <= wr_bits;  // 1 blocks the bit
    end
  end

  // set and status writes become one-cycle strobes
  assign set_en   = reg_wr_en & sel_set;
  assign set_bits = wr_bits;
  assign clr_en   = reg_wr_en & sel_status;  // write one to clear
  assign clr_bits = wr_bits;

  ////////////////////////////////////////
  // read mux
  ////////////////////////////////////////
  // values seen here are from before any write of this cycle
  always_comb begin
    reg_rd_data = '0;
    if (reg_rd_en) begin
      if (sel_version) begin
        reg_rd_data = `GLB_HW_VERSION;
      end else if (sel_mask) begin
        reg_rd_data = csb_data_t'(done_mask);
      end else if (sel_status) begin
        reg_rd_data = csb_data_t'(done_status);
      end
      // set register and unmapped offsets read 0
    end
  end

  // the csb stage issues either a read or a write, never both
  property p_rd_wr_exclusive;
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
      !(reg_wr_en && reg_rd_en);
  endproperty
  a_rd_wr_exclusive: assert property (p_rd_wr_exclusive)
    else $error("glb_reg: read and write strobes in the same cycle");

endmodule

// ==== hw/glb_csb.sv ====
////////////////////////////////////////
// csb front end: one register access per request strobe,
// packed response two cycles after the request
////////////////////////////////////////

`timescale 1ns/1ns

module glb_csb (
  input  logic                nvdla_core_clk,
  input  logic                nvdla_core_rstn,
  input  logic                req_valid,
  input  glb_pkg::csb_req_t   req_pd,
  input  glb_pkg::csb_data_t  reg_rd_data,
  input  logic                reg_err,
  output logic                resp_valid,
  output glb_pkg::csb_resp_t  resp_pd,
  output logic                reg_wr_en,
  output logic                reg_rd_en,
  output glb_pkg::reg_ofs_t   reg_offset,
  output glb_pkg::csb_data_t  reg_wr_data
);

  import glb_pkg::*;

  logic      req_vld;
  csb_req_t  req_q;
  csb_addr_t req_addr;
  logic      req_write;
  logic      req_nposted;

  logic      rsp_rd_vld;
  logic      rsp_wr_vld;
  logic      rsp_vld;
  csb_resp_t rsp_rd_pd;
  csb_resp_t rsp_wr_pd;
  csb_resp_t rsp_pd;

  ////////////////////////////////////////
  // request stage
  ////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      req_vld <= 1'b0;
      req_q   <= '0;
    end else begin
      req_vld <= req_valid;
      if (req_valid) begin
        req_q <= req_pd;  // hold last packet
      end
    end
  end

  assign req_addr    = req_q.addr;
  assign req_write   = req_q.write;
  assign req_nposted = req_q.nposted;

  // glb space is 1k words, offset in bytes
  assign reg_offset  = {req_addr[9:0], 2'b00};
  assign reg_wr_data = req_q.wdat;
  assign reg_wr_en   = req_vld & req_write;
  assign reg_rd_en   = req_vld & ~req_write;

  ////////////////////////////////////////
  // response build
  ////////////////////////////////////////
  assign rsp_rd_vld = reg_rd_en;
  assign rsp_wr_vld = reg_wr_en & req_nposted;  // posted writes stay silent
  assign rsp_vld    = rsp_rd_vld | rsp_wr_vld;

  assign rsp_rd_pd.is_write_resp = 1'b0;
  assign rsp_rd_pd.error         = reg_err;
  assign rsp_rd_pd.rdata         = reg_rd_data;  // already 0 when unmapped

  assign rsp_wr_pd.is_write_resp = 1'b1;
  assign rsp_wr_pd.error         = reg_err;
  assign rsp_wr_pd.rdata         = '0;

  assign rsp_pd = rsp_rd_vld ? rsp_rd_pd : rsp_wr_pd;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= rsp_vld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (rsp_vld) begin
      resp_pd <= rsp_pd;
    end
  end

  // every answer traces back to a strobe two cycles before
  property p_resp_after_req;
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
      resp_valid |-> $past(req_valid, 2);
  endproperty
  a_resp_after_req: assert property (p_resp_after_req)
    else $error("glb_csb: response without a request two cycles earlier");

endmodule

// ==== hw/glb_pkg.sv ====
////////////////////////////////////////
// shared types of the global control unit: csb packets,
// data words, done vectors and the register offset enum
////////////////////////////////////////

`include "glb_defines.svh"

package glb_pkg;

  typedef logic [21:0] csb_addr_t;  // word address
  typedef logic [31:0] csb_data_t;
  typedef logic [11:0] reg_ofs_t;   // byte offset inside glb

  // bit 2k group 0, bit 2k+1 group 1
  // engine order bdma, cdp, pdp, sdp, cdma_dat, cdma_wt, cacc
  typedef logic [`GLB_NUM_DONE-1:0] done_vec_t;

  ////////////////////////////////////////
  // csb request, 63 bits
  ////////////////////////////////////////
  typedef struct packed {
    logic [1:0] level;    // not used here
    logic [3:0] wrbe;     // not used here
    logic       srcpriv;  // not used here
    logic       nposted;  // write expects an answer
    logic       write;
    csb_data_t  wdat;
    csb_addr_t  addr;
  } csb_req_t;

  // csb response, 34 bits
  typedef struct packed {
    logic      is_write_resp;
    logic      error;
    csb_data_t rdata;
  } csb_resp_t;

  typedef enum reg_ofs_t {
    GLB_REG_VERSION = `GLB_OFS_VERSION,
    GLB_REG_MASK    = `GLB_OFS_MASK,
    GLB_REG_SET     = `GLB_OFS_SET,
    GLB_REG_STATUS  = `GLB_OFS_STATUS
  } glb_reg_e;

endpackage

// ==== hw/glb_defines.svh ====
////////////////////////////////////////
// register map and constants of the global control unit
// include wherever offsets or the version word are needed
////////////////////////////////////////

`ifndef GLB_DEFINES_SVH
`define GLB_DEFINES_SVH

////////////////////////////////////////
// byte offsets inside the glb space
////////////////////////////////////////
`define GLB_OFS_VERSION 12'h000    // read only
`define GLB_OFS_MASK    12'h004    // read and write
`define GLB_OFS_SET     12'h008    // write only, reads 0
`define GLB_OFS_STATUS  12'h00C    // write one to clear

////////////////////////////////////////
// fixed values
////////////////////////////////////////
`define GLB_HW_VERSION  32'h0001_0003  // major.minor of this unit

// seven engines with two ping-pong groups each
`define GLB_NUM_DONE    14

`endif
